/* hdl/periph_settings.svh */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Peripheral windows, byte addresses.
`define SPI_BASE        32'hFF000000
`define SYSCON_BASE     32'hFF000010
`define TIMER_BASE      32'hFF000080
`define WINDOW_WORDS    4

// Word offsets inside each window.
`define SPI_DATA_OFS    2'd0
`define SPI_STAT_OFS    2'd1
`define SYSCON_CMD_OFS  2'd0
`define TMR_MTIME_LO    2'd0
`define TMR_MTIME_HI    2'd1
`define TMR_CMP_LO      2'd2
`define TMR_CMP_HI      2'd3

// Clock cycles per mtime tick.
`define TIMER_DIV       100

`define REBOOT_CODE     8'h77
`define POWEROFF_CODE   8'h55

`endif

/* hdl/memBusPkg.sv */
package memBusPkg;

    // Core-side bus uses word addresses throughout.
    typedef logic [29:0] wordAddr_t;

    typedef logic [31:0] busData_t;

    // One enable per byte lane with bit 0 the lowest lane.
    typedef logic [3:0] byteMask_t;

    // Word offset inside a four-word peripheral window.
    typedef logic [1:0] regOffset_t;

endpackage

/* hdl/periphPkg.sv */
package periphPkg;

    // Transfer length, picked by the write mask.
    typedef enum logic [1:0] {
        eight,
        sixteen,
        thirtyTwo
    } spiLen_t;

    // SPI status register layout.
    typedef struct packed {
        logic [22:0] rsvdHi;
        logic        rxValid;  // Bit 8.
        logic [6:0]  rsvdLo;
        logic        busy;     // Bit 0.
    } spiStatus_t;

    typedef enum logic [1:0] {
        selNone,
        selSpi,
        selSysCon,
        selTimer
    } periphSel_t;

endpackage

/* hdl/aclintTimer.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module aclintTimer
    import memBusPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        re,
    input  logic        we,
    input  regOffset_t  offset,
    input  byteMask_t   wmask,
    input  busData_t    wdata,
    output busData_t    rdata,
    output logic        rvalid,
    output logic [63:0] mtime,
    output logic        timerIrq
);

    localparam int DivW = $clog2(`TIMER_DIV);

    logic [DivW-1:0] divCnt;
    logic [63:0]     mtimeCmp;
    logic [63:0]     mtimeNext;
    logic            tick;

    function automatic busData_t mergeBytes(busData_t old, busData_t val, byteMask_t m);
        busData_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (m[i])
                res[8*i +: 8] = val[8*i +: 8];
        end
        return res;
    endfunction

    assign tick = (divCnt == '0);

    // Software write wins over the tick.
    always_comb begin
        mtimeNext = tick ? mtime + 64'd1 : mtime;
        if (we && offset == `TMR_MTIME_LO)
            mtimeNext = {mtime[63:32], mergeBytes(mtime[31:0], wdata, wmask)};
        else if (we && offset == `TMR_MTIME_HI)
            mtimeNext = {mergeBytes(mtime[63:32], wdata, wmask), mtime[31:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            divCnt   <= DivW'(`TIMER_DIV - 1);
            mtime    <= '0;
            mtimeCmp <= '1;
            timerIrq <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            divCnt   <= tick ? DivW'(`TIMER_DIV - 1) : divCnt - 1'b1;
            mtime    <= mtimeNext;
            timerIrq <= (mtime >= mtimeCmp);
            rvalid   <= re;
            if (we && offset == `TMR_CMP_LO)
                mtimeCmp[31:0] <= mergeBytes(mtimeCmp[31:0], wdata, wmask);
            if (we && offset == `TMR_CMP_HI)
                mtimeCmp[63:32] <= mergeBytes(mtimeCmp[63:32], wdata, wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            case (offset)
                `TMR_MTIME_LO: rdata <= mtime[31:0];
                `TMR_MTIME_HI: rdata <= mtime[63:32];
                `TMR_CMP_LO:   rdata <= mtimeCmp[31:0];
                default:       rdata <= mtimeCmp[63:32];
            endcase
        end
    end

endmodule

/* hdl/spiMaster.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module spiMaster
    import memBusPkg::*;
    import periphPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       re,
    input  logic       we,
    input  regOffset_t offset,
    input  byteMask_t  wmask,
    input  busData_t   wdata,
    output busData_t   rdata,
    output logic       rvalid,
    output logic       busy,
    output logic       spiCs,
    output logic       spiClk,
    output logic       spiMosi,
    input  logic       spiMiso
);

    spiLen_t    wrLen;
    logic [5:0] wrBits;
    busData_t   wrFrame;
    logic [5:0] bitCnt;    // Rising edges still to go.
    busData_t   shiftReg;
    logic [7:0] rxData;
    logic       rxValid;
    logic       start;
    spiStatus_t status;

    function automatic spiLen_t lenFromMask(byteMask_t m);
        case (m)
            4'b0001: return eight;
            4'b0011: return sixteen;
            default: return thirtyTwo;
        endcase
    endfunction

    assign wrLen = lenFromMask(wmask);
    assign start = we && (offset == `SPI_DATA_OFS);

    // Payload goes MSB first, so left-align it.
    always_comb begin
        case (wrLen)
            eight: begin
                wrBits  = 6'd8;
                wrFrame = {wdata[7:0], 24'b0};
            end
            sixteen: begin
                wrBits  = 6'd16;
                wrFrame = {wdata[15:0], 16'b0};
            end
            default: begin
                wrBits  = 6'd32;
                wrFrame = wdata;
            end
        endcase
    end

    assign busy = ~spiCs;

    always_comb begin
        status         = '0;
        status.busy    = busy;
        status.rxValid = rxValid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spiCs   <= 1'b1;
            spiClk  <= 1'b0;
            spiMosi <= 1'b0;
            bitCnt  <= '0;
            rxData  <= '0;
            rxValid <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rvalid <= re;
            if (re && offset == `SPI_DATA_OFS)
                rxValid <= 1'b0;  // Data read consumes the byte.

            if (!spiCs) begin
                if (spiClk) begin
                    spiClk  <= 1'b0;
                    spiMosi <= shiftReg[31];
                end else if (bitCnt != '0) begin
                    spiClk   <= 1'b1;
                    bitCnt   <= bitCnt - 1'b1;
                    shiftReg <= {shiftReg[30:0], spiMiso};
                end else begin
                    spiCs   <= 1'b1;
                    rxData  <= shiftReg[7:0];
                    rxValid <= 1'b1;
                end
            end

            if (start) begin
                spiCs    <= 1'b0;
                spiClk   <= 1'b0;
                bitCnt   <= wrBits;
                shiftReg <= wrFrame;
                spiMosi  <= wrFrame[31];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            case (offset)
                `SPI_DATA_OFS: rdata <= {24'b0, rxData};
                `SPI_STAT_OFS: rdata <= status;
                default:       rdata <= '0;
            endcase
        end
    end

endmodule

/* hdl/sysCon.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module sysCon
    import memBusPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       re,
    input  logic       we,
    input  regOffset_t offset,
    input  byteMask_t  wmask,
    input  busData_t   wdata,
    output busData_t   rdata,
    output logic       rvalid,
    output logic       reboot,
    output logic       powerOff
);

    logic cmdWrite;

    // Only the low byte carries a command.
    assign cmdWrite = we && (offset == `SYSCON_CMD_OFS) && wmask[0];

    assign rdata = '0;  // Write-only block.

    always_ff @(posedge clk) begin
        if (rst) begin
            reboot   <= 1'b0;
            powerOff <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rvalid   <= re;
            reboot   <= cmdWrite && (wdata[7:0] == `REBOOT_CODE);
            powerOff <= cmdWrite && (wdata[7:0] == `POWEROFF_CODE);
        end
    end

endmodule

/* hdl/periphDecode.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module periphDecode
    import memBusPkg::*;
    import periphPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       re,
    input  wordAddr_t  raddr,
    input  logic       we,
    input  wordAddr_t  waddr,
    output regOffset_t offset,
    output logic       spiRe,
    output logic       spiWe,
    output logic       sysRe,
    output logic       sysWe,
    output logic       tmrRe,
    output logic       tmrWe,
    input  busData_t   spiRdata,
    input  busData_t   sysRdata,
    input  busData_t   tmrRdata,
    input  logic       spiRvalid,
    input  logic       sysRvalid,
    input  logic       tmrRvalid,
    output busData_t   rdata,
    output logic       rvalid
);

    periphSel_t rdSel;
    periphSel_t sel;   // Peripheral answering this cycle.
    logic       miss;

    function automatic logic inWindow(wordAddr_t addr, logic [31:0] base);
        wordAddr_t baseWord;
        baseWord = base[31:2];
        return (addr >= baseWord) && (addr < baseWord + `WINDOW_WORDS);
    endfunction

    always_comb begin
        if (inWindow(raddr, `SPI_BASE))
            rdSel = selSpi;
        else if (inWindow(raddr, `SYSCON_BASE))
            rdSel = selSysCon;
        else if (inWindow(raddr, `TIMER_BASE))
            rdSel = selTimer;
        else
            rdSel = selNone;
    end

    assign spiRe = re && (rdSel == selSpi);
    assign sysRe = re && (rdSel == selSysCon);
    assign tmrRe = re && (rdSel == selTimer);

    assign spiWe = we && inWindow(waddr, `SPI_BASE);
    assign sysWe = we && inWindow(waddr, `SYSCON_BASE);
    assign tmrWe = we && inWindow(waddr, `TIMER_BASE);

    // Windows are aligned, so the low address bits are the offset.
    assign offset = we ? regOffset_t'(waddr) : regOffset_t'(raddr);

    always_ff @(posedge clk) begin
        if (rst) begin
            sel  <= selNone;
            miss <= 1'b0;
        end else begin
            sel  <= re ? rdSel : selNone;
            miss <= re && (rdSel == selNone);
        end
    end

    always_comb begin
        case (sel)
            selSpi: begin
                rdata  = spiRdata;
                rvalid = spiRvalid;
            end
            selSysCon: begin
                rdata  = sysRdata;
                rvalid = sysRvalid;
            end
            selTimer: begin
                rdata  = tmrRdata;
                rvalid = tmrRvalid;
            end
            default: begin
                rdata  = '0;
                rvalid = miss;  // Unmapped read gets zero.
            end
        endcase
    end

endmodule

/* hdl/periphTop.sv */
`timescale 1ns/1ps

module periphTop
    import memBusPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        re,
    input  wordAddr_t   raddr,
    output busData_t    rdata,
    output logic        rvalid,
    output logic        rbusy,
    input  logic        we,
    input  wordAddr_t   waddr,
    input  byteMask_t   wmask,
    input  busData_t    wdata,
    output logic [63:0] mtime,
    output logic        timerIrq,
    output logic        spiCs,
    output logic        spiClk,
    output logic        spiMosi,
    input  logic        spiMiso,
    output logic        reboot,
    output logic        powerOff
);

    regOffset_t offset;
    logic       spiRe;
    logic       spiWe;
    logic       sysRe;
    logic       sysWe;
    logic       tmrRe;
    logic       tmrWe;
    busData_t   spiRdata;
    busData_t   sysRdata;
    busData_t   tmrRdata;
    logic       spiRvalid;
    logic       sysRvalid;
    logic       tmrRvalid;

    periphDecode decode0 (
        .clk(clk), .rst(rst),
        .re(re), .raddr(raddr), .we(we), .waddr(waddr),
        .offset(offset),
        .spiRe(spiRe), .spiWe(spiWe),
        .sysRe(sysRe), .sysWe(sysWe),
        .tmrRe(tmrRe), .tmrWe(tmrWe),
        .spiRdata(spiRdata), .sysRdata(sysRdata), .tmrRdata(tmrRdata),
        .spiRvalid(spiRvalid), .sysRvalid(sysRvalid), .tmrRvalid(tmrRvalid),
        .rdata(rdata), .rvalid(rvalid)
    );

    aclintTimer timer0 (
        .clk(clk), .rst(rst),
        .re(tmrRe), .we(tmrWe), .offset(offset), .wmask(wmask), .wdata(wdata),
        .rdata(tmrRdata), .rvalid(tmrRvalid),
        .mtime(mtime), .timerIrq(timerIrq)
    );

    // SPI busy is the only source of back-pressure.
    spiMaster spi0 (
        .clk(clk), .rst(rst),
        .re(spiRe), .we(spiWe), .offset(offset), .wmask(wmask), .wdata(wdata),
        .rdata(spiRdata), .rvalid(spiRvalid), .busy(rbusy),
        .spiCs(spiCs), .spiClk(spiClk), .spiMosi(spiMosi), .spiMiso(spiMiso)
    );

    sysCon sysCon0 (
        .clk(clk), .rst(rst),
        .re(sysRe), .we(sysWe), .offset(offset), .wmask(wmask), .wdata(wdata),
        .rdata(sysRdata), .rvalid(sysRvalid),
        .reboot(reboot), .powerOff(powerOff)
    );

endmodule

/* verif/periph_sva.sv */
`timescale 1ns/1ps

module periphSva (
    input logic clk,
    input logic rst,
    input logic re,
    input logic we,
    input logic rvalid,
    input logic rbusy,
    input logic reboot,
    input logic powerOff,
    input logic spiCs,
    input logic spiClk
);

    int failCount = 0;

    assert property (@(posedge clk) disable iff (rst) re |=> rvalid)
        else begin
            failCount++;
            $error("rvalid missing one cycle after re");
        end

    assert property (@(posedge clk) disable iff (rst) rvalid |-> $past(re))
        else begin
            failCount++;
            $error("rvalid without a read one cycle earlier");
        end

    assert property (@(posedge clk) disable iff (rst) reboot |=> !reboot)
        else begin
            failCount++;
            $error("reboot pulse longer than one cycle");
        end

    assert property (@(posedge clk) disable iff (rst) powerOff |=> !powerOff)
        else begin
            failCount++;
            $error("powerOff pulse longer than one cycle");
        end

    // Serial clock is quiet outside a frame.
    assert property (@(posedge clk) disable iff (rst)
        (spiClk != $past(spiClk)) |-> !$past(spiCs))
        else begin
            failCount++;
            $error("spiClk toggled while spiCs was high");
        end

    assert property (@(posedge clk) disable iff (rst) (re || we) |-> !rbusy)
        else begin
            failCount++;
            $error("bus access issued while rbusy was high");
        end

endmodule

bind periphTop periphSva sva0 (.*);

/* verif/periphTb.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module periphTb
    import memBusPkg::*;
    import periphPkg::*;
();

    localparam int ClkPeriod   = 100;
    localparam int NumTxn      = 120;
    localparam int WorstCycles = 70;
    localparam int WatchdogNs  = NumTxn * WorstCycles * ClkPeriod + 50000;

    localparam wordAddr_t SpiData = wordAddr_t'(`SPI_BASE >> 2);
    localparam wordAddr_t SpiStat = SpiData + 1;
    localparam wordAddr_t SysCmd  = wordAddr_t'(`SYSCON_BASE >> 2);
    localparam wordAddr_t TmrBase = wordAddr_t'(`TIMER_BASE >> 2);
    localparam wordAddr_t MtLo    = TmrBase;
    localparam wordAddr_t MtHi    = TmrBase + 1;
    localparam wordAddr_t CmpLo   = TmrBase + 2;
    localparam wordAddr_t CmpHi   = TmrBase + 3;

    logic        clk;
    logic        rst;
    logic        re;
    wordAddr_t   raddr;
    busData_t    rdata;
    logic        rvalid;
    logic        rbusy;
    logic        we;
    wordAddr_t   waddr;
    byteMask_t   wmask;
    busData_t    wdata;
    logic [63:0] mtime;
    logic        timerIrq;
    logic        spiCs;
    logic        spiClk;
    logic        spiMosi;
    logic        spiMiso;
    logic        reboot;
    logic        powerOff;

    integer      seed;
    int          cycleCnt = 0;
    int          checks = 0;
    int          errors = 0;
    int          testNum = 0;
    int          errsAtStart;
    busData_t    slaveShift;   // Miso bits with the next one at the top.
    busData_t    mosiRec;
    int          mosiCnt;
    logic [7:0]  expRx;
    logic [63:0] shadowCmp;

    periphTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // SPI slave drives a bit as the frame opens and after each falling spiClk.
    always @(negedge spiCs) begin
        @(negedge clk);
        spiMiso = slaveShift[31];
    end

    always @(negedge spiClk) begin
        slaveShift = slaveShift << 1;
        @(negedge clk);
        spiMiso = slaveShift[31];
    end

    always @(posedge spiClk) begin
        if (!spiCs) begin
            mosiRec = {mosiRec[30:0], spiMosi};
            mosiCnt++;
        end
    end

    function automatic int bitsOf(spiLen_t len);
        case (len)
            eight:   return 8;
            sixteen: return 16;
            default: return 32;
        endcase
    endfunction

    function automatic busData_t maskedMerge(busData_t old, busData_t val, byteMask_t m);
        busData_t lanes;
        lanes = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
        return (old & ~lanes) | (val & lanes);
    endfunction

    task automatic checkData(string name, busData_t got, busData_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkWindow(string name, busData_t got, busData_t lo, busData_t hi);
        checks++;
        if ($isunknown(got) || got < lo || got > hi) begin
            errors++;
            $display("FAIL %s: got %h, expected %h to %h", name, got, lo, hi);
        end
    endtask

    task automatic checkFrame(busData_t sent, spiLen_t len);
        int       n;
        busData_t exp;
        n = bitsOf(len);
        exp = (n == 32) ? sent : sent & ((32'd1 << n) - 1);
        checks++;
        if (mosiCnt != n || mosiRec !== exp) begin
            errors++;
            $display("FAIL spiMosi: got %h in %0d bits, expected %h in %0d bits",
                     mosiRec, mosiCnt, exp, n);
        end
    endtask

    // Starts on a falling edge and returns one falling edge later.
    task automatic busWrite(wordAddr_t addr, byteMask_t m, busData_t d);
        while (rbusy)
            @(negedge clk);
        we = 1'b1;
        waddr = addr;
        wmask = m;
        wdata = d;
        @(negedge clk);
        we = 1'b0;
    endtask

    task automatic busRead(wordAddr_t addr, output busData_t data);
        while (rbusy)
            @(negedge clk);
        re = 1'b1;
        raddr = addr;
        @(negedge clk);
        re = 1'b0;
        checkFlag("rvalid", rvalid, 1'b1);
        data = rdata;
    endtask

    task automatic endTest(string name);
        testNum++;
        $display("Test %0d %s: %s", testNum, name,
                 (errors == errsAtStart) ? "ok" : "mismatches");
        errsAtStart = errors;
    endtask

    task automatic timerCmpTest();
        byteMask_t m;
        busData_t  d;
        busData_t  got;
        shadowCmp = '1;
        for (int i = 0; i < 8; i++) begin
            m = byteMask_t'($random(seed));
            d = $random(seed);
            if ($random(seed) & 1) begin
                busWrite(CmpHi, m, d);
                shadowCmp[63:32] = maskedMerge(shadowCmp[63:32], d, m);
            end else begin
                busWrite(CmpLo, m, d);
                shadowCmp[31:0] = maskedMerge(shadowCmp[31:0], d, m);
            end
            busRead(CmpLo, got);
            checkData("mtimecmp low", got, shadowCmp[31:0]);
            busRead(CmpHi, got);
            checkData("mtimecmp high", got, shadowCmp[63:32]);
        end
    endtask

    task automatic timerCountTest();
        busData_t wHi;
        busData_t wLo;
        busData_t got;
        int       tWrite;
        int       elapsed;
        for (int i = 0; i < 2; i++) begin
            wHi = $random(seed) & 32'hFF;
            wLo = $random(seed) & 32'h0FFF_FFFF;  // Keeps the low word from carrying.
            busWrite(MtHi, 4'hF, wHi);
            tWrite = cycleCnt;
            busWrite(MtLo, 4'hF, wLo);
            repeat (100 + ($unsigned($random(seed)) % 256)) @(negedge clk);
            elapsed = cycleCnt - tWrite;
            checkWindow("mtime output low", mtime[31:0], wLo, wLo + elapsed / `TIMER_DIV + 1);
            checkData("mtime output high", mtime[63:32], wHi);
            busRead(MtLo, got);
            checkWindow("mtime low", got, wLo, wLo + elapsed / `TIMER_DIV + 1);
            busRead(MtHi, got);
            checkData("mtime high", got, wHi);
            busWrite(CmpHi, 4'hF, wHi);
            busWrite(CmpLo, 4'hF, wLo);
            repeat (2) @(negedge clk);
            checkFlag("timerIrq", timerIrq, 1'b1);
            busWrite(CmpHi, 4'hF, wHi + 1);
            repeat (2) @(negedge clk);
            checkFlag("timerIrq", timerIrq, 1'b0);
        end
    endtask

    task automatic spiTransfer(byteMask_t m, busData_t payload);
        spiLen_t  len;
        busData_t slaveFrame;
        int       waited;
        len = (m == 4'b0001) ? eight : (m == 4'b0011) ? sixteen : thirtyTwo;
        slaveFrame = $random(seed);
        slaveShift = slaveFrame << (32 - bitsOf(len));
        mosiRec = '0;
        mosiCnt = 0;
        busWrite(SpiData, m, payload);
        waited = 0;
        while (rbusy && waited < WorstCycles) begin
            @(negedge clk);
            waited++;
        end
        if (rbusy) begin
            errors++;
            $display("SPI transfer still busy after %0d cycles", WorstCycles);
        end
        expRx = slaveFrame[7:0];  // Last byte on miso.
        checkFrame(payload, len);
        checkFlag("spiCs", spiCs, 1'b1);
    endtask

    function automatic byteMask_t randomSpiMask();
        case ($unsigned($random(seed)) % 3)
            0:       return 4'b0001;
            1:       return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic spiRxTest();
        busData_t   got;
        spiStatus_t st;
        for (int i = 0; i < 3; i++) begin
            spiTransfer(randomSpiMask(), $random(seed));
            st = '0;
            st.rxValid = 1'b1;
            busRead(SpiStat, got);
            checkData("spi status", got, busData_t'(st));
            busRead(SpiData, got);
            checkData("spi rxData", got, {24'b0, expRx});
            busRead(SpiStat, got);
            checkData("spi status", got, 32'h0);
        end
    endtask

    task automatic sysConTest();
        byteMask_t m;
        busData_t  d;
        logic      expReboot;
        logic      expOff;
        for (int i = 0; i < 10; i++) begin
            d = $random(seed);
            m = byteMask_t'($random(seed));
            case ($unsigned($random(seed)) % 4)
                0: d[7:0] = `REBOOT_CODE;
                1: d[7:0] = `POWEROFF_CODE;
                default: ;
            endcase
            if (i == 0) begin
                d[7:0] = `REBOOT_CODE;
                m = 4'hF;
            end else if (i == 1) begin
                d[7:0] = `POWEROFF_CODE;
                m = 4'h1;
            end
            expReboot = m[0] && (d[7:0] == 8'h77);
            expOff = m[0] && (d[7:0] == 8'h55);
            busWrite(SysCmd, m, d);
            for (int k = 0; k < 3; k++) begin
                checkFlag("reboot", reboot, expReboot && k == 0);
                checkFlag("powerOff", powerOff, expOff && k == 0);
                @(negedge clk);
            end
        end
    endtask

    function automatic logic isMapped(wordAddr_t a);
        return (a >= SpiData && a < SpiData + `WINDOW_WORDS) ||
               (a >= SysCmd && a < SysCmd + `WINDOW_WORDS) ||
               (a >= TmrBase && a < TmrBase + `WINDOW_WORDS);
    endfunction

    task automatic unmappedTest();
        wordAddr_t a;
        busData_t  got;
        for (int i = 0; i < 8; i++) begin
            do begin
                if (i % 2 == 0)
                    a = SpiData + ($unsigned($random(seed)) % 64);  // Gaps near the windows.
                else
                    a = wordAddr_t'($random(seed));
            end while (isMapped(a));
            busRead(a, got);
            checkData("unmapped rdata", got, 32'h0);
        end
    endtask

    initial begin
        #(WatchdogNs);
        $display("Watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed = 32'hcde1;
        rst = 1'b1;
        re = 1'b0;
        raddr = '0;
        we = 1'b0;
        waddr = '0;
        wmask = '0;
        wdata = '0;
        spiMiso = 1'b0;
        slaveShift = '0;
        mosiRec = '0;
        mosiCnt = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        errsAtStart = 0;

        timerCmpTest();
        endTest("mtimecmp byte writes");
        timerCountTest();
        endTest("mtime count and timerIrq");
        for (int i = 0; i < 12; i++)
            spiTransfer(randomSpiMask(), $random(seed));
        endTest("SPI mosi frames");
        spiRxTest();
        endTest("SPI receive and status");
        sysConTest();
        endTest("SysCon pulses");
        unmappedTest();
        endTest("unmapped reads");

        errors += dut0.sva0.failCount;
        $display("%0d tests, %0d checks, %0d errors", testNum, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/memBusPkg.sv
hdl/periphPkg.sv
hdl/aclintTimer.sv
hdl/spiMaster.sv
hdl/sysCon.sv
hdl/periphDecode.sv
hdl/periphTop.sv
verif/periph_sva.sv
verif/periphTb.sv
